/* design/ep_dma_ctrl.sv */
`include "ep_settings.svh"

module ep_dma_ctrl import ep_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dma_cfg_t             dma_cfg_i,
    input  logic                 dma_abort_i,
    input  logic                 cfg_bus_mstr_en_i,
    input  logic                 timeframe_end_rise_i,
    output logic [`EP_XY_AW-1:0] xy_buf_addr_o,
    input  logic [`EP_DW_W-1:0]  xy_buf_dat_i,
    output logic                 mwr_req_o,
    output dma_word_t            mwr_word_o,
    input  logic                 mwr_done_i,
    output logic                 dma_busy_o,
    output logic                 frame_done_o,
    output logic                 dma_irq_o
);

    dma_state_e           state;
    logic [`EP_XY_AW-1:0] word_cnt;
    logic [31:0]          addr_acc;
    logic                 start;
    logic                 last_word;

    assign xy_buf_addr_o = word_cnt;
    assign dma_busy_o    = state != DMA_IDLE;
    assign dma_irq_o     = frame_done_o;
    assign last_word     = word_cnt == dma_cfg_i.frame_len - 1'b1;
    assign start         = timeframe_end_rise_i && dma_cfg_i.enable && cfg_bus_mstr_en_i
                           && dma_cfg_i.frame_len != '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= DMA_IDLE;
            mwr_req_o    <= 1'b0;
            frame_done_o <= 1'b0;
            word_cnt     <= '0;
        end else begin
            frame_done_o <= 1'b0;
            if (dma_abort_i) begin
                state     <= DMA_IDLE;
                mwr_req_o <= 1'b0;
            end else begin
                case (state)
                    DMA_IDLE: if (start) begin
                        word_cnt <= '0;
                        addr_acc <= dma_cfg_i.host_addr;
                        state    <= DMA_FETCH;
                    end
                    DMA_FETCH: state <= DMA_SEND;   // Buffer read latency
                    DMA_SEND: begin
                        mwr_word_o <= '{addr: addr_acc, data: xy_buf_dat_i};
                        mwr_req_o  <= 1'b1;
                        state      <= DMA_WAIT;
                    end
                    DMA_WAIT: if (mwr_done_i) begin
                        mwr_req_o <= 1'b0;
                        if (last_word) begin
                            frame_done_o <= 1'b1;
                            state        <= DMA_IDLE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            addr_acc <= addr_acc + 32'd8;
                            state    <= DMA_FETCH;
                        end
                    end
                    default: state <= DMA_IDLE;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (mwr_req_o && !mwr_done_i && !dma_abort_i) |=> (mwr_req_o && $stable(mwr_word_o)))
        else $error("dma: write request changed before done");

endmodule

/* design/ep_pkg.sv */
`include "ep_settings.svh"

package ep_pkg;

    typedef struct packed {
        logic [`EP_DW_W-1:0]  data;   // DW0 in the upper half
        logic [`EP_REM_W-1:0] rem_n;
        logic                 sof_n;
        logic                 eof_n;
    } ll_beat_t;

    typedef enum logic [1:0] {TLP_MWR, TLP_MRD, TLP_OTHER} tlp_kind_e;

    typedef enum logic [1:0] {RX_IDLE, RX_HDR2, RX_WAIT_CPL} rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_CPL0, TX_CPL1, TX_MWR0, TX_MWR1, TX_MWR2
    } tx_state_e;

    typedef enum logic [1:0] {DMA_IDLE, DMA_FETCH, DMA_SEND, DMA_WAIT} dma_state_e;

    typedef struct packed {
        logic                  strobe;
        logic [`EP_REG_AW-3:0] offset;   // DW offset
        logic [31:0]           data;
        logic [3:0]            fbe;
    } reg_wr_t;

    typedef struct packed {
        logic [15:0] rid;
        logic [7:0]  tag;
        logic [2:0]  tc;
        logic [1:0]  attr;
        logic [6:0]  lower_addr;
    } rd_req_t;

    typedef struct packed {
        logic                 enable;
        logic [31:0]          host_addr;
        logic [`EP_XY_AW-1:0] frame_len;
    } dma_cfg_t;

    typedef struct packed {
        logic [31:0]         addr;
        logic [`EP_DW_W-1:0] data;
    } dma_word_t;

endpackage

/* design/ep_regs.sv */
`include "ep_settings.svh"

module ep_regs import ep_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  reg_wr_t     reg_wr_i,
    input  logic        rd_req_i,
    input  rd_req_t     rd_info_i,
    output logic        cpl_req_o,
    output rd_req_t     cpl_info_o,
    output logic [31:0] cpl_data_o,
    input  logic        cpl_done_i,
    output dma_cfg_t    dma_cfg_o,
    output logic        dma_abort_o,
    input  logic        dma_busy_i,
    input  logic        frame_done_i
);

    logic [`EP_REG_AW-1:0] wr_off;
    logic [31:0]           wr_mask;
    logic [31:0]           rd_data;
    logic [31:0]           addr_new;
    logic [31:0]           len_new;
    logic [15:0]           frame_cnt;
    logic                  init_wr;

    assign wr_off  = {reg_wr_i.offset, 2'b00};
    assign wr_mask = {{8{reg_wr_i.fbe[3]}}, {8{reg_wr_i.fbe[2]}},
                      {8{reg_wr_i.fbe[1]}}, {8{reg_wr_i.fbe[0]}}};
    assign init_wr = reg_wr_i.strobe && wr_off == `EP_REG_CTRL
                     && reg_wr_i.fbe[0] && reg_wr_i.data[1];

    // Byte-enable merge with the current contents
    assign addr_new = (dma_cfg_o.host_addr & ~wr_mask) | (reg_wr_i.data & wr_mask);
    assign len_new  = ({{(32-`EP_XY_AW){1'b0}}, dma_cfg_o.frame_len} & ~wr_mask)
                      | (reg_wr_i.data & wr_mask);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dma_cfg_o   <= '0;
            frame_cnt   <= '0;
            dma_abort_o <= 1'b0;
        end else begin
            dma_abort_o <= init_wr;
            if (reg_wr_i.strobe && wr_off == `EP_REG_DMA_ADDR)
                dma_cfg_o.host_addr <= {addr_new[31:3], 3'b000};
            if (reg_wr_i.strobe && wr_off == `EP_REG_FRAME_LEN)
                dma_cfg_o.frame_len <= len_new[`EP_XY_AW-1:0];
            if (init_wr) begin
                dma_cfg_o.enable <= 1'b0;
                frame_cnt        <= '0;
            end else begin
                if (reg_wr_i.strobe && wr_off == `EP_REG_CTRL && reg_wr_i.fbe[0])
                    dma_cfg_o.enable <= reg_wr_i.data[0];
                if (frame_done_i)
                    frame_cnt <= frame_cnt + 16'd1;
            end
        end
    end

    always_comb begin
        case (rd_info_i.lower_addr[`EP_REG_AW-1:0])
            `EP_REG_CTRL:      rd_data = {31'd0, dma_cfg_o.enable};
            `EP_REG_DMA_ADDR:  rd_data = dma_cfg_o.host_addr;
            `EP_REG_FRAME_LEN: rd_data = {{(32-`EP_XY_AW){1'b0}}, dma_cfg_o.frame_len};
            `EP_REG_STATUS:    rd_data = {15'd0, dma_busy_i, frame_cnt};
            `EP_REG_VERSION:   rd_data = `EP_VERSION;
            default:           rd_data = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            cpl_req_o <= 1'b0;
        else if (rd_req_i)
            cpl_req_o <= 1'b1;
        else if (cpl_done_i)
            cpl_req_o <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_req_i) begin
            cpl_info_o <= rd_info_i;
            cpl_data_o <= rd_data;   // Snapshot at request time
        end
    end

    // rx must stall until the previous completion has gone out
    assert property (@(posedge clk) disable iff (!rst_n) rd_req_i |-> !cpl_req_o)
        else $error("regs: read request while a completion is pending");

endmodule

/* design/ep_rx_engine.sv */
`include "ep_settings.svh"

module ep_rx_engine import ep_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ll_beat_t rx_beat_i,
    input  logic     rx_src_rdy_n_i,
    output logic     rx_dst_rdy_n_o,
    output reg_wr_t  reg_wr_o,
    output logic     rd_req_o,
    output rd_req_t  rd_info_o,
    input  logic     cpl_done_i
);

    rx_state_e   state;
    tlp_kind_e   kind_q;
    tlp_kind_e   kind_d;
    rd_req_t     info_q;
    logic [3:0]  fbe_q;
    logic        xfer;
    logic [31:0] dw_hi;
    logic [31:0] dw_lo;

    assign xfer      = !rx_src_rdy_n_i && !rx_dst_rdy_n_o;
    assign dw_hi     = rx_beat_i.data[63:32];
    assign dw_lo     = rx_beat_i.data[31:0];
    assign rd_info_o = info_q;

    always_comb begin
        kind_d = TLP_OTHER;
        if (dw_hi[28:24] == `EP_TYPE_MEM) begin
            if (dw_hi[31:29] == `EP_FMT_3DW_DATA)
                kind_d = TLP_MWR;
            else if (dw_hi[31:29] == `EP_FMT_3DW_NODATA)
                kind_d = TLP_MRD;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= RX_IDLE;
            rx_dst_rdy_n_o  <= 1'b1;
            reg_wr_o.strobe <= 1'b0;
            rd_req_o        <= 1'b0;
        end else begin
            reg_wr_o.strobe <= 1'b0;
            rd_req_o        <= 1'b0;
            case (state)
                RX_IDLE: begin
                    rx_dst_rdy_n_o <= 1'b0;
                    if (xfer && !rx_beat_i.sof_n) begin
                        kind_q      <= kind_d;
                        info_q.tc   <= dw_hi[22:20];
                        info_q.attr <= dw_hi[13:12];
                        info_q.rid  <= dw_lo[31:16];
                        info_q.tag  <= dw_lo[15:8];
                        fbe_q       <= dw_lo[3:0];
                        if (rx_beat_i.eof_n)
                            state <= RX_HDR2;
                    end
                end
                RX_HDR2: if (xfer && !rx_beat_i.eof_n) begin
                    reg_wr_o.offset   <= dw_hi[`EP_REG_AW-1:2];   // Address DW
                    reg_wr_o.data     <= dw_lo;
                    reg_wr_o.fbe      <= fbe_q;
                    info_q.lower_addr <= {dw_hi[6:2], 2'b00};
                    reg_wr_o.strobe   <= kind_q == TLP_MWR;
                    if (kind_q == TLP_MRD) begin
                        rd_req_o       <= 1'b1;
                        rx_dst_rdy_n_o <= 1'b1;   // Single read in flight
                        state          <= RX_WAIT_CPL;
                    end else begin
                        state <= RX_IDLE;
                    end
                end
                RX_WAIT_CPL: if (cpl_done_i) begin
                    rx_dst_rdy_n_o <= 1'b0;
                    state          <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (state == RX_HDR2 && xfer) |-> rx_beat_i.sof_n)
        else $error("rx: sof_n low inside a TLP");

endmodule

/* design/ep_settings.svh */
`ifndef EP_SETTINGS_SVH
`define EP_SETTINGS_SVH

`define EP_DW_W           64
`define EP_REM_W          8
`define EP_XY_AW          10
`define EP_REG_AW         5

// Byte offsets in the register window
`define EP_REG_CTRL       5'h00
`define EP_REG_DMA_ADDR   5'h04
`define EP_REG_FRAME_LEN  5'h08
`define EP_REG_STATUS     5'h0C
`define EP_REG_VERSION    5'h10
`define EP_VERSION        32'h0001_0400

`define EP_FMT_3DW_NODATA 3'b000
`define EP_FMT_3DW_DATA   3'b010
`define EP_TYPE_MEM       5'b00000
`define EP_TYPE_CPL       5'b01010

`define EP_REM_FULL       8'h00
`define EP_REM_HALF       8'h0F   // Lower DW of the beat invalid

`endif

/* design/ep_top.sv */
`include "ep_settings.svh"

module ep_top import ep_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ll_beat_t             rx_beat_i,
    input  logic                 rx_src_rdy_n_i,
    output logic                 rx_dst_rdy_n_o,
    output ll_beat_t             tx_beat_o,
    output logic                 tx_src_rdy_n_o,
    input  logic                 tx_dst_rdy_n_i,
    input  logic [15:0]          completer_id_i,
    input  logic                 cfg_bus_mstr_en_i,
    input  logic                 timeframe_end_rise_i,
    output logic [`EP_XY_AW-1:0] xy_buf_addr_o,
    input  logic [`EP_DW_W-1:0]  xy_buf_dat_i,
    output logic                 dma_irq_o
);

    reg_wr_t     reg_wr;
    logic        rd_req;
    rd_req_t     rd_info;
    logic        cpl_req;
    rd_req_t     cpl_info;
    logic [31:0] cpl_data;
    logic        cpl_done;
    dma_cfg_t    dma_cfg;
    logic        dma_abort;
    logic        dma_busy;
    logic        frame_done;
    logic        mwr_req;
    dma_word_t   mwr_word;
    logic        mwr_done;

    ep_rx_engine u_rx (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_beat_i      (rx_beat_i),
        .rx_src_rdy_n_i (rx_src_rdy_n_i),
        .rx_dst_rdy_n_o (rx_dst_rdy_n_o),
        .reg_wr_o       (reg_wr),
        .rd_req_o       (rd_req),
        .rd_info_o      (rd_info),
        .cpl_done_i     (cpl_done)
    );

    ep_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr_i     (reg_wr),
        .rd_req_i     (rd_req),
        .rd_info_i    (rd_info),
        .cpl_req_o    (cpl_req),
        .cpl_info_o   (cpl_info),
        .cpl_data_o   (cpl_data),
        .cpl_done_i   (cpl_done),
        .dma_cfg_o    (dma_cfg),
        .dma_abort_o  (dma_abort),
        .dma_busy_i   (dma_busy),
        .frame_done_i (frame_done)
    );

    ep_dma_ctrl u_dma (
        .clk                  (clk),
        .rst_n                (rst_n),
        .dma_cfg_i            (dma_cfg),
        .dma_abort_i          (dma_abort),
        .cfg_bus_mstr_en_i    (cfg_bus_mstr_en_i),
        .timeframe_end_rise_i (timeframe_end_rise_i),
        .xy_buf_addr_o        (xy_buf_addr_o),
        .xy_buf_dat_i         (xy_buf_dat_i),
        .mwr_req_o            (mwr_req),
        .mwr_word_o           (mwr_word),
        .mwr_done_i           (mwr_done),
        .dma_busy_o           (dma_busy),
        .frame_done_o         (frame_done),
        .dma_irq_o            (dma_irq_o)
    );

    ep_tx_engine u_tx (
        .clk            (clk),
        .rst_n          (rst_n),
        .completer_id_i (completer_id_i),
        .cpl_req_i      (cpl_req),
        .cpl_info_i     (cpl_info),
        .cpl_data_i     (cpl_data),
        .cpl_done_o     (cpl_done),
        .mwr_req_i      (mwr_req),
        .mwr_word_i     (mwr_word),
        .mwr_done_o     (mwr_done),
        .tx_beat_o      (tx_beat_o),
        .tx_src_rdy_n_o (tx_src_rdy_n_o),
        .tx_dst_rdy_n_i (tx_dst_rdy_n_i)
    );

endmodule

/* design/ep_tx_engine.sv */
`include "ep_settings.svh"

module ep_tx_engine import ep_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] completer_id_i,
    input  logic        cpl_req_i,
    input  rd_req_t     cpl_info_i,
    input  logic [31:0] cpl_data_i,
    output logic        cpl_done_o,
    input  logic        mwr_req_i,
    input  dma_word_t   mwr_word_i,
    output logic        mwr_done_o,
    output ll_beat_t    tx_beat_o,
    output logic        tx_src_rdy_n_o,
    input  logic        tx_dst_rdy_n_i
);

    tx_state_e   state;
    logic        xfer;
    logic [31:0] cpl_dw0;
    logic [31:0] cpl_dw1;
    logic [31:0] cpl_dw2;
    logic [31:0] mwr_dw0;
    logic [31:0] mwr_dw1;
    ll_beat_t    cpl_beat0;
    ll_beat_t    cpl_beat1;
    ll_beat_t    mwr_beat0;
    ll_beat_t    mwr_beat1;
    ll_beat_t    mwr_beat2;

    assign xfer = !tx_src_rdy_n_o && !tx_dst_rdy_n_i;

    // CplD, one DW of data
    assign cpl_dw0 = {`EP_FMT_3DW_DATA, `EP_TYPE_CPL, 1'b0, cpl_info_i.tc, 4'b0000,
                      2'b00, cpl_info_i.attr, 2'b00, 10'd1};
    assign cpl_dw1 = {completer_id_i, 3'b000, 1'b0, 12'd4};   // Status SC, 4 bytes
    assign cpl_dw2 = {cpl_info_i.rid, cpl_info_i.tag, 1'b0, cpl_info_i.lower_addr};

    // MWr32 of two DW, all bytes enabled
    assign mwr_dw0 = {`EP_FMT_3DW_DATA, `EP_TYPE_MEM, 1'b0, 3'b000, 4'b0000,
                      4'b0000, 2'b00, 10'd2};
    assign mwr_dw1 = {completer_id_i, 8'h00, 4'hF, 4'hF};

    assign cpl_beat0 = '{data: {cpl_dw0, cpl_dw1}, rem_n: `EP_REM_FULL,
                         sof_n: 1'b0, eof_n: 1'b1};
    assign cpl_beat1 = '{data: {cpl_dw2, cpl_data_i}, rem_n: `EP_REM_FULL,
                         sof_n: 1'b1, eof_n: 1'b0};
    assign mwr_beat0 = '{data: {mwr_dw0, mwr_dw1}, rem_n: `EP_REM_FULL,
                         sof_n: 1'b0, eof_n: 1'b1};
    assign mwr_beat1 = '{data: {mwr_word_i.addr[31:2], 2'b00, mwr_word_i.data[63:32]},
                         rem_n: `EP_REM_FULL, sof_n: 1'b1, eof_n: 1'b1};
    assign mwr_beat2 = '{data: {mwr_word_i.data[31:0], 32'd0}, rem_n: `EP_REM_HALF,
                         sof_n: 1'b1, eof_n: 1'b0};

    assign cpl_done_o = state == TX_CPL1 && xfer;
    assign mwr_done_o = state == TX_MWR2 && xfer;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= TX_IDLE;
            tx_src_rdy_n_o <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (cpl_req_i) begin   // Completion first at a TLP boundary
                        tx_beat_o      <= cpl_beat0;
                        tx_src_rdy_n_o <= 1'b0;
                        state          <= TX_CPL0;
                    end else if (mwr_req_i) begin
                        tx_beat_o      <= mwr_beat0;
                        tx_src_rdy_n_o <= 1'b0;
                        state          <= TX_MWR0;
                    end
                end
                TX_CPL0: if (xfer) begin
                    tx_beat_o <= cpl_beat1;
                    state     <= TX_CPL1;
                end
                TX_MWR0: if (xfer) begin
                    tx_beat_o <= mwr_beat1;
                    state     <= TX_MWR1;
                end
                TX_MWR1: if (xfer) begin
                    tx_beat_o <= mwr_beat2;
                    state     <= TX_MWR2;
                end
                TX_CPL1, TX_MWR2: if (xfer) begin
                    tx_src_rdy_n_o <= 1'b1;
                    state          <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (!tx_src_rdy_n_o && tx_dst_rdy_n_i) |=> (!tx_src_rdy_n_o && $stable(tx_beat_o)))
        else $error("tx: beat changed while stalled");

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ep -o sim_ep

out=$(./obj_dir/sim_ep || true)
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi

/* sim/ep_tests.txt */
# op a b: W offset data | R offset expected | O offset data (TLP of another kind)
# F read offset during the frame (ff for none) and its expected value | X init reset
R 10 00010400
R 14 00000000
W 04 12345677
R 04 12345670
W 08 00000405
R 08 00000005
W 10 ffffffff
R 10 00010400
R 1c 00000000
F ff 00000000
R 0c 00000000
W 00 00000001
R 00 00000001
F ff 00000000
R 0c 00000001
W 04 80001000
W 08 00000008
F 0c 00010001
R 0c 00000002
O 00 00000000
O 08 00000003
R 00 00000001
R 08 00000008
X 00 00000000
R 00 00000000
R 0c 00000000
F 00 00000000
R 04 80001000

/* sim/tb_ep.sv */
`include "ep_settings.svh"

module tb_ep import ep_pkg::*; ();

    localparam logic [31:0] BAR_BASE = 32'hF000_0000;
    localparam int          CMP_W    = $bits(ll_beat_t);

    logic                 clk;
    logic                 rst_n;
    ll_beat_t             rx_beat_i;
    logic                 rx_src_rdy_n_i;
    logic                 rx_dst_rdy_n_o;
    ll_beat_t             tx_beat_o;
    logic                 tx_src_rdy_n_o;
    logic                 tx_dst_rdy_n_i;
    logic [15:0]          completer_id_i;
    logic                 cfg_bus_mstr_en_i;
    logic                 timeframe_end_rise_i;
    logic [`EP_XY_AW-1:0] xy_buf_addr_o;
    logic [`EP_DW_W-1:0]  xy_buf_dat_i;
    logic                 dma_irq_o;

    integer               seed = 32'hf7a9;
    integer               cycles = 0;
    integer               cycle_limit = 0;
    integer               irq_cnt = 0;
    integer               irq_exp = 0;
    byte                  ops[$];
    logic [31:0]          arg_a[$];
    logic [31:0]          arg_b[$];
    ll_beat_t             beats[$];
    logic                 model_en;
    logic [31:0]          model_addr;
    logic [9:0]           model_len;
    logic [7:0]           next_tag;
    logic [`EP_XY_AW-1:0] xy_addr_q;

    ep_top uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .rx_beat_i            (rx_beat_i),
        .rx_src_rdy_n_i       (rx_src_rdy_n_i),
        .rx_dst_rdy_n_o       (rx_dst_rdy_n_o),
        .tx_beat_o            (tx_beat_o),
        .tx_src_rdy_n_o       (tx_src_rdy_n_o),
        .tx_dst_rdy_n_i       (tx_dst_rdy_n_i),
        .completer_id_i       (completer_id_i),
        .cfg_bus_mstr_en_i    (cfg_bus_mstr_en_i),
        .timeframe_end_rise_i (timeframe_end_rise_i),
        .xy_buf_addr_o        (xy_buf_addr_o),
        .xy_buf_dat_i         (xy_buf_dat_i),
        .dma_irq_o            (dma_irq_o)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        tx_dst_rdy_n_i <= 1'($random(seed));   // Random back-pressure
        xy_addr_q      <= xy_buf_addr_o;       // Buffer read latency
        xy_buf_dat_i   <= {32'hA5A5_0000 + 32'(xy_addr_q), ~32'(xy_addr_q)};
    end

    // tx monitor and irq counter
    always @(posedge clk) begin
        if (rst_n && !tx_src_rdy_n_o && !tx_dst_rdy_n_i)
            beats.push_back(tx_beat_o);
        if (rst_n && dma_irq_o)
            irq_cnt = irq_cnt + 1;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: no progress after %0d cycles", cycles);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    task automatic compare(input string name, input logic [CMP_W-1:0] got,
                           input logic [CMP_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "test stopped");
    endtask

    function automatic ll_beat_t make_beat(input logic [31:0] hi, input logic [31:0] lo,
                                           input logic [7:0] rem_n, input logic sof_n,
                                           input logic eof_n);
        make_beat = '{data: {hi, lo}, rem_n: rem_n, sof_n: sof_n, eof_n: eof_n};
    endfunction

    // Starts and ends at a falling edge
    task automatic send_beat(input ll_beat_t b);
        rx_beat_i      = b;
        rx_src_rdy_n_i = 1'b0;
        while (rx_dst_rdy_n_o)
            @(negedge clk);
        @(negedge clk);
        rx_src_rdy_n_i = 1'b1;
    endtask

    task automatic send_tlp(input logic [2:0] fmt, input logic [4:0] typ,
                            input logic [4:0] off, input logic [31:0] data);
        logic [31:0] dw0;
        logic [31:0] dw1;
        dw0 = {fmt, typ, 1'b0, next_tag[2:0], 4'h0, 2'b00, next_tag[1:0], 2'b00, 10'd1};
        dw1 = {8'h01, next_tag, next_tag, 8'h0F};   // Requester id, tag, BEs
        send_beat(make_beat(dw0, dw1, `EP_REM_FULL, 1'b0, 1'b1));
        send_beat(make_beat(BAR_BASE | {27'd0, off}, data,
                            fmt[1] ? `EP_REM_FULL : `EP_REM_HALF, 1'b1, 1'b0));
    endtask

    task automatic write_reg(input logic [4:0] off, input logic [31:0] data);
        send_tlp(`EP_FMT_3DW_DATA, `EP_TYPE_MEM, off, data);
        case (off)
            `EP_REG_CTRL:      model_en = data[1] ? 1'b0 : data[0];
            `EP_REG_DMA_ADDR:  model_addr = {data[31:3], 3'b000};
            `EP_REG_FRAME_LEN: model_len = data[9:0];
            default: ;
        endcase
    endtask

    task automatic pop_beat(output ll_beat_t b);
        while (beats.size() == 0)
            @(posedge clk);
        b = beats.pop_front();
    endtask

    // Takes TLPs until n_mwr writes and the pending CplD have gone by
    task automatic collect(input integer n_mwr, input logic cpl_due, input logic [4:0] off,
                           input logic [31:0] cpl_exp);
        ll_beat_t    b0;
        ll_beat_t    b1;
        ll_beat_t    b2;
        logic [31:0] k32;
        integer      k;
        logic        cpl_seen;
        k        = 0;
        cpl_seen = !cpl_due;
        while (k < n_mwr || !cpl_seen) begin
            pop_beat(b0);
            pop_beat(b1);
            if (b0.data[60:56] == `EP_TYPE_CPL && !cpl_seen) begin
                compare("tx_beat_o CplD beat 0", b0, make_beat(
                    {`EP_FMT_3DW_DATA, `EP_TYPE_CPL, 1'b0, next_tag[2:0], 4'h0, 2'b00,
                     next_tag[1:0], 2'b00, 10'd1},
                    {completer_id_i, 4'h0, 12'd4}, `EP_REM_FULL, 1'b0, 1'b1));
                compare("tx_beat_o CplD beat 1", b1, make_beat(
                    {8'h01, next_tag, next_tag, 3'b000, off}, cpl_exp,
                    `EP_REM_FULL, 1'b1, 1'b0));
                cpl_seen = 1'b1;
            end else if (k < n_mwr) begin
                pop_beat(b2);
                k32 = 32'(k);
                compare("tx_beat_o MWr beat 0", b0, make_beat(
                    {`EP_FMT_3DW_DATA, `EP_TYPE_MEM, 24'd2},
                    {completer_id_i, 8'h00, 8'hFF}, `EP_REM_FULL, 1'b0, 1'b1));
                compare("tx_beat_o MWr beat 1", b1, make_beat(
                    model_addr + {k32[28:0], 3'b000}, 32'hA5A5_0000 + k32,
                    `EP_REM_FULL, 1'b1, 1'b1));
                b2.data[31:0] = 32'd0;   // Not valid under half rem
                compare("tx_beat_o MWr beat 2", b2,
                        make_beat(~k32, 32'd0, `EP_REM_HALF, 1'b1, 1'b0));
                k = k + 1;
            end else begin
                fail("Unexpected TLP on the tx stream");
            end
        end
    endtask

    task automatic run_frame(input logic [31:0] rd_off, input logic [31:0] rd_exp);
        logic   active;
        logic   has_rd;
        integer n;
        active = model_en && model_len != 10'd0;
        has_rd = rd_off != 32'hFF;
        n      = active ? int'(model_len) : 0;
        timeframe_end_rise_i = 1'b1;
        @(negedge clk);
        timeframe_end_rise_i = 1'b0;
        @(negedge clk);
        timeframe_end_rise_i = 1'b1;   // Lands while the frame is busy
        @(negedge clk);
        timeframe_end_rise_i = 1'b0;
        if (has_rd)
            send_tlp(`EP_FMT_3DW_NODATA, `EP_TYPE_MEM, rd_off[4:0], 32'd0);
        collect(n, has_rd, rd_off[4:0], rd_exp);
        if (has_rd)
            next_tag = next_tag + 8'd1;
        if (active) begin
            irq_exp = irq_exp + 1;
            while (irq_cnt < irq_exp)
                @(posedge clk);
        end else begin
            repeat (20) @(negedge clk);
            if (beats.size() != 0)
                fail("MWr sent for a frame-end pulse that should be ignored");
        end
        compare("dma_irq_o pulses", CMP_W'(irq_cnt), CMP_W'(irq_exp));
    endtask

    initial begin
        integer      fd;
        integer      status;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        clk                  = 1'b0;
        rst_n                = 1'b0;
        rx_beat_i            = '0;
        rx_src_rdy_n_i       = 1'b1;
        tx_dst_rdy_n_i       = 1'b1;
        completer_id_i       = 16'h01A0;
        cfg_bus_mstr_en_i    = 1'b1;
        timeframe_end_rise_i = 1'b0;
        xy_buf_dat_i         = '0;
        xy_addr_q            = '0;
        model_en             = 1'b0;
        model_addr           = 32'd0;
        model_len            = 10'd0;
        next_tag             = 8'd0;

        fd = $fopen("sim/ep_tests.txt", "r");
        if (fd == 0)
            fail("Cannot open sim/ep_tests.txt");
        while (!$feof(fd)) begin
            line   = "";
            status = $fgets(line, fd);
            if (status > 0 && line.len() > 2 && line[0] != "#") begin
                status = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
                ops.push_back(line[0]);
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
        end
        $fclose(fd);
        cycle_limit = 300 * ops.size();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < ops.size(); i++) begin
            @(negedge clk);
            case (ops[i])
                "W": write_reg(arg_a[i][4:0], arg_b[i]);
                "X": write_reg(`EP_REG_CTRL, 32'h2);   // Init reset bit
                "O": send_tlp(`EP_FMT_3DW_DATA, `EP_TYPE_CPL, arg_a[i][4:0], arg_b[i]);
                "F": run_frame(arg_a[i], arg_b[i]);
                "R": begin
                    send_tlp(`EP_FMT_3DW_NODATA, `EP_TYPE_MEM, arg_a[i][4:0], 32'd0);
                    collect(0, 1'b1, arg_a[i][4:0], arg_b[i]);
                    next_tag = next_tag + 8'd1;
                end
                default: fail("Unknown operation in the test file");
            endcase
        end

        repeat (20) @(negedge clk);
        compare("dma_irq_o pulses", CMP_W'(irq_cnt), CMP_W'(irq_exp));
        if (beats.size() != 0) begin
            $display("%0d stray beats left on the tx stream", beats.size());
            $display("Verification failed");
            $fatal(1, "stray TLP");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+design
design/ep_pkg.sv
design/ep_rx_engine.sv
design/ep_regs.sv
design/ep_dma_ctrl.sv
design/ep_tx_engine.sv
design/ep_top.sv
sim/tb_ep.sv
